// File: src/exec_pkg.sv
// Execute datapath package
// Widths, register file size, opcodes and divider constants

package exec_pkg;

    // --------------------
    // Widths and sizes
    // --------------------
    localparam int XLEN      = 32; // Data width
    localparam int REG_COUNT = 32; // General registers
    localparam int REG_AW    = 5;  // Register index width
    localparam int SHAMT_W   = 5;  // Shift amount width

    // --------------------
    // Divider
    // --------------------
    localparam int DIV_STEPS = 32; // Quotient digits per division
    localparam int DIV_CNT_W = 5;  // Step counter width

    typedef logic [XLEN-1:0]   xdata_t;
    typedef logic [REG_AW-1:0] reg_idx_t;

    // --------------------
    // Opcodes
    // --------------------
    typedef enum logic [4:0]
    {
        OP_ADD, OP_SUB,                         // Arithmetic
        OP_SLL, OP_SRL, OP_SRA,                 // Shifts
        OP_SLT, OP_SLTU,                        // Set less than
        OP_XOR, OP_OR, OP_AND,                  // Logic
        OP_MIN, OP_MAX, OP_MINU, OP_MAXU,       // Min and max
        OP_MUL, OP_MULH, OP_MULHU, OP_MULHSU,   // Multiplier
        OP_DIV, OP_DIVU, OP_REM, OP_REMU        // Divider
    } exec_op_e;

endpackage

// File: src/int_regfile.sv
// Integer register file
// 32 x 32 with x0 tied to zero, two read ports, one execute write port and a debug port

`timescale 1ns/1ps

module int_regfile
(
    input  logic              CLK,
    input  logic              RES_CPU,
    input  exec_pkg::reg_idx_t rd_addr1,  // Source 1 index
    input  exec_pkg::reg_idx_t rd_addr2,  // Source 2 index
    output exec_pkg::xdata_t   rd_data1,
    output exec_pkg::xdata_t   rd_data2,
    input  logic               wr_en,     // Execute write
    input  exec_pkg::reg_idx_t wr_addr,
    input  exec_pkg::xdata_t   wr_data,
    input  logic               dbg_req,   // Debug access
    input  logic               dbg_write,
    input  exec_pkg::reg_idx_t dbg_addr,
    input  exec_pkg::xdata_t   dbg_wdata,
    output exec_pkg::xdata_t   dbg_rdata
);
    import exec_pkg::*;

    xdata_t rf [REG_COUNT];

    // x0 is only ever cleared by reset
    always_ff @(posedge CLK or posedge RES_CPU)
    begin
        if (RES_CPU)
        begin
            for (int i = 0; i < REG_COUNT; i++)
            begin
                rf[i] <= '0;
            end
        end
        else
        begin
            for (int i = 1; i < REG_COUNT; i++)
            begin
                if (dbg_req && dbg_write && (dbg_addr == REG_AW'(i)))
                    rf[i] <= dbg_wdata;                  // Debug wins
                else if (wr_en && (wr_addr == REG_AW'(i)))
                    rf[i] <= wr_data;
            end
        end
    end

    assign rd_data1 = rf[rd_addr1];
    assign rd_data2 = rf[rd_addr2];

    always_ff @(posedge CLK or posedge RES_CPU)
    begin
        if (RES_CPU)
            dbg_rdata <= '0;
        else if (dbg_req && !dbg_write)
            dbg_rdata <= rf[dbg_addr];
        else
            dbg_rdata <= '0;                             // Zero when no read
    end

endmodule

// File: src/operand_forward.sv
// Operand selection for the issue stage
// Picks register file data, the EX-stage bypass or the immediate

`timescale 1ns/1ps

module operand_forward
(
    input  exec_pkg::reg_idx_t issue_rs1,
    input  exec_pkg::reg_idx_t issue_rs2,
    input  exec_pkg::xdata_t   rf_data1,
    input  exec_pkg::xdata_t   rf_data2,
    input  logic               ex_wr_en,    // EX result valid this cycle
    input  exec_pkg::reg_idx_t ex_wr_addr,
    input  exec_pkg::xdata_t   ex_result,
    input  logic               issue_use_imm,
    input  exec_pkg::xdata_t   issue_imm,
    output exec_pkg::xdata_t   op_a,
    output exec_pkg::xdata_t   op_b
);

    logic fwd_a;
    logic fwd_b;

    // --------------------
    // Bypass match
    // --------------------
    assign fwd_a = ex_wr_en && (ex_wr_addr == issue_rs1) && (issue_rs1 != '0);
    assign fwd_b = ex_wr_en && (ex_wr_addr == issue_rs2) && (issue_rs2 != '0);

    assign op_a = fwd_a ? ex_result : rf_data1;

    always_comb
    begin
        if (issue_use_imm)
            op_b = issue_imm;                            // Immediate form
        else if (fwd_b)
            op_b = ex_result;
        else
            op_b = rf_data2;
    end

endmodule

// File: src/int_alu.sv
// Integer ALU
// Add/sub, shifts, set-less-than, logic and min/max in one combinational stage

`timescale 1ns/1ps

module int_alu
(
    input  exec_pkg::exec_op_e op,
    input  exec_pkg::xdata_t   op_a,
    input  exec_pkg::xdata_t   op_b,
    output exec_pkg::xdata_t   result
);
    import exec_pkg::*;

    logic [SHAMT_W-1:0] shamt;
    logic               lt_s;
    logic               lt_u;
    xdata_t             sum;
    xdata_t             diff;

    assign shamt = op_b[SHAMT_W-1:0];                    // Same for reg and imm
    assign lt_s  = $signed(op_a) < $signed(op_b);
    assign lt_u  = op_a < op_b;
    assign sum   = op_a + op_b;
    assign diff  = op_a - op_b;

    always_comb
    begin
        case (op)
            OP_ADD  : result = sum;
            OP_SUB  : result = diff;
            OP_SLL  : result = op_a << shamt;
            OP_SRL  : result = op_a >> shamt;
            OP_SRA  : result = xdata_t'($signed(op_a) >>> shamt);
            OP_SLT  : result = {{(XLEN-1){1'b0}}, lt_s};
            OP_SLTU : result = {{(XLEN-1){1'b0}}, lt_u};
            OP_XOR  : result = op_a ^ op_b;
            OP_OR   : result = op_a | op_b;
            OP_AND  : result = op_a & op_b;
            OP_MIN  : result = lt_s ? op_a : op_b;
            OP_MAX  : result = lt_s ? op_b : op_a;
            OP_MINU : result = lt_u ? op_a : op_b;
            OP_MAXU : result = lt_u ? op_b : op_a;
            default : result = '0;                       // Mul and div ops
        endcase
    end

endmodule

// File: src/int_multiplier.sv
// Integer multiplier
// 33 x 33 signed product covering MUL, MULH, MULHU and MULHSU

`timescale 1ns/1ps

module int_multiplier
(
    input  exec_pkg::exec_op_e op,
    input  exec_pkg::xdata_t   op_a,
    input  exec_pkg::xdata_t   op_b,
    output exec_pkg::xdata_t   result
);
    import exec_pkg::*;

    logic                   a_signed;
    logic                   b_signed;
    logic signed [XLEN:0]   a_ext;
    logic signed [XLEN:0]   b_ext;
    logic signed [2*XLEN+1:0] product;

    assign a_signed = (op != OP_MULHU);
    assign b_signed = (op == OP_MUL) || (op == OP_MULH);

    // One extra bit turns unsigned operands into positive signed ones
    assign a_ext = {a_signed & op_a[XLEN-1], op_a};
    assign b_ext = {b_signed & op_b[XLEN-1], op_b};

    assign product = a_ext * b_ext;

    assign result = (op == OP_MUL) ? product[XLEN-1:0]  // Low word
                                   : product[2*XLEN-1:XLEN];

endmodule

// File: src/int_divider.sv
// Integer divider
// Non-restoring, one quotient digit per cycle, post correction and RISC-V illegal cases

`timescale 1ns/1ps

module int_divider
(
    input  logic               CLK,
    input  logic               RES_CPU,
    input  logic               start,     // Load operands this edge
    input  exec_pkg::exec_op_e op,
    input  exec_pkg::xdata_t   dividend,
    input  exec_pkg::xdata_t   divisor,
    output logic               busy,
    output logic               done,      // Result valid for one cycle
    output exec_pkg::xdata_t   result
);
    import exec_pkg::*;

    logic                 signed_op;
    logic                 a_sign;
    logic                 b_sign;
    logic                 last_step;
    logic [DIV_CNT_W-1:0] step_cnt;
    exec_op_e             op_q;
    xdata_t               dvd_orig;
    xdata_t               dvd_shift;
    logic                 dvd_sign;
    xdata_t               dsor;
    logic                 dsor_sign;
    logic [XLEN:0]        dsor_ext;
    logic [XLEN:0]        rem;                           // Partial remainder with sign
    logic [XLEN:0]        part;
    xdata_t               quot;
    logic                 div_zero;
    logic                 div_ovf;
    xdata_t               q_fix;
    logic [XLEN:0]        r_fix;
    xdata_t               quot_out;
    xdata_t               rem_out;

    assign signed_op = (op == OP_DIV) || (op == OP_REM);
    assign a_sign    = signed_op & dividend[XLEN-1];
    assign b_sign    = signed_op & divisor[XLEN-1];
    assign dsor_ext  = {dsor_sign, dsor};
    assign part      = {rem[XLEN-1:0], dvd_shift[XLEN-1]};
    assign last_step = (step_cnt == DIV_CNT_W'(DIV_STEPS - 1));

    // --------------------
    // Sequencing
    // --------------------
    always_ff @(posedge CLK or posedge RES_CPU)
    begin
        if (RES_CPU)
        begin
            busy     <= 1'b0;
            done     <= 1'b0;
            step_cnt <= '0;
        end
        else if (start)
        begin
            busy     <= 1'b1;
            done     <= 1'b0;
            step_cnt <= '0;
        end
        else if (done)
        begin
            busy <= 1'b0;                                // Result taken this edge
            done <= 1'b0;
        end
        else if (busy && last_step)
            done <= 1'b1;                                // Correction edge
        else if (busy)
            step_cnt <= step_cnt + 1'b1;
    end

    // --------------------
    // Iteration
    // --------------------
    always_ff @(posedge CLK)
    begin
        if (start)
        begin
            op_q      <= op;
            dvd_orig  <= dividend;
            dvd_shift <= {dividend[XLEN-2:0], 1'b0};
            dvd_sign  <= a_sign;
            dsor      <= divisor;
            dsor_sign <= b_sign;
            div_zero  <= (divisor == '0);
            div_ovf   <= signed_op && (dividend == {1'b1, {(XLEN-1){1'b0}}})
                                   && (divisor == '1);
            if (a_sign == b_sign)
            begin
                rem  <= {{XLEN{a_sign}}, dividend[XLEN-1]} - {b_sign, divisor};
                quot <= xdata_t'(1);
            end
            else
            begin
                rem  <= {{XLEN{a_sign}}, dividend[XLEN-1]} + {b_sign, divisor};
                quot <= '0;
            end
        end
        else if (busy && !last_step)
        begin
            dvd_shift <= {dvd_shift[XLEN-2:0], 1'b0};
            if (rem[XLEN] == dsor_sign)
            begin
                rem  <= part - dsor_ext;
                quot <= {quot[XLEN-2:0], 1'b1};
            end
            else
            begin
                rem  <= part + dsor_ext;
                quot <= {quot[XLEN-2:0], 1'b0};
            end
        end
        else if (busy && !done)
        begin
            quot_out <= q_fix;
            rem_out  <= r_fix[XLEN-1:0];
        end
    end

    // --------------------
    // Post correction
    // --------------------
    always_comb
    begin
        q_fix = {quot[XLEN-2:0], 1'b1};                  // Digits {-1,+1} to binary
        r_fix = rem;
        // Remainder must carry the dividend's sign
        if (!dvd_sign && r_fix[XLEN])
        begin
            r_fix = dsor_sign ? r_fix - dsor_ext : r_fix + dsor_ext;
            q_fix = dsor_sign ? q_fix + 1'b1 : q_fix - 1'b1;
        end
        else if (dvd_sign && !r_fix[XLEN])
        begin
            r_fix = dsor_sign ? r_fix + dsor_ext : r_fix - dsor_ext;
            q_fix = dsor_sign ? q_fix - 1'b1 : q_fix + 1'b1;
        end
        // Remainder of exactly one divisor
        if ((r_fix + dsor_ext) == '0)
        begin
            r_fix = '0;
            q_fix = q_fix - 1'b1;
        end
        else if ((r_fix - dsor_ext) == '0)
        begin
            r_fix = '0;
            q_fix = q_fix + 1'b1;
        end
        if (div_zero)
        begin
            q_fix = '1;
            r_fix = {1'b0, dvd_orig};
        end
        else if (div_ovf)
        begin
            q_fix = {1'b1, {(XLEN-1){1'b0}}};
            r_fix = '0;
        end
    end

    assign result = ((op_q == OP_DIV) || (op_q == OP_DIVU)) ? quot_out : rem_out;

endmodule

// File: src/ex_writeback.sv
// EX stage register and register write-back
// Holds the issued operation, starts the divider and arbitrates the write port

`timescale 1ns/1ps

module ex_writeback
(
    input  logic               CLK,
    input  logic               RES_CPU,
    input  logic               issue_fire,   // Accepted this edge
    input  exec_pkg::exec_op_e issue_op,
    input  exec_pkg::reg_idx_t issue_rd,
    input  exec_pkg::xdata_t   op_a,
    input  exec_pkg::xdata_t   op_b,
    input  exec_pkg::xdata_t   alu_result,
    input  exec_pkg::xdata_t   mul_result,
    input  logic               div_done,
    input  exec_pkg::xdata_t   div_result,
    output exec_pkg::exec_op_e ex_op,
    output exec_pkg::xdata_t   ex_a,
    output exec_pkg::xdata_t   ex_b,
    output logic               div_start,
    output logic               wr_en,
    output exec_pkg::reg_idx_t wr_addr,
    output exec_pkg::xdata_t   wr_data
);
    import exec_pkg::*;

    logic     ex_valid;
    logic     issue_is_div;
    logic     ex_is_mul;
    reg_idx_t ex_rd;
    reg_idx_t div_rd;                                    // Pending divide destination

    assign issue_is_div = issue_op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    assign ex_is_mul    = ex_op inside {OP_MUL, OP_MULH, OP_MULHU, OP_MULHSU};
    assign div_start    = issue_fire & issue_is_div;

    always_ff @(posedge CLK or posedge RES_CPU)
    begin
        if (RES_CPU)
            ex_valid <= 1'b0;
        else
            ex_valid <= issue_fire & ~issue_is_div;      // Divides write later
    end

    always_ff @(posedge CLK)
    begin
        if (issue_fire)
        begin
            ex_op <= issue_op;
            ex_rd <= issue_rd;
            ex_a  <= op_a;
            ex_b  <= op_b;
        end
        if (div_start)
            div_rd <= issue_rd;
    end

    // Issue is held off while the divider runs, so no collision
    assign wr_en   = ex_valid | div_done;
    assign wr_addr = div_done ? div_rd : ex_rd;
    assign wr_data = div_done  ? div_result
                   : ex_is_mul ? mul_result
                   : alu_result;

endmodule

// File: src/int_exec_unit.sv
// Integer execute unit top level
// Register file, operand bypass, ALU, multiplier and divider

`timescale 1ns/1ps

module int_exec_unit
(
    input  logic               CLK,
    input  logic               RES_CPU,
    input  logic               issue_valid,   // Issue port
    input  exec_pkg::exec_op_e issue_op,
    input  exec_pkg::reg_idx_t issue_rs1,
    input  exec_pkg::reg_idx_t issue_rs2,
    input  exec_pkg::reg_idx_t issue_rd,
    input  logic               issue_use_imm,
    input  exec_pkg::xdata_t   issue_imm,
    output logic               busy,          // Divider running
    input  logic               dbg_req,       // Debug port
    input  logic               dbg_write,
    input  exec_pkg::reg_idx_t dbg_addr,
    input  exec_pkg::xdata_t   dbg_wdata,
    output exec_pkg::xdata_t   dbg_rdata
);
    import exec_pkg::*;

    logic     issue_fire;
    xdata_t   rf_data1;
    xdata_t   rf_data2;
    xdata_t   op_a;
    xdata_t   op_b;
    exec_op_e ex_op;
    xdata_t   ex_a;
    xdata_t   ex_b;
    xdata_t   alu_result;
    xdata_t   mul_result;
    logic     div_start;
    logic     div_done;
    xdata_t   div_result;
    logic     wr_en;
    reg_idx_t wr_addr;
    xdata_t   wr_data;

    assign issue_fire = issue_valid & ~busy;

    // --------------------
    // ID stage
    // --------------------
    int_regfile u_regfile
    (
        .CLK       (CLK),
        .RES_CPU   (RES_CPU),
        .rd_addr1  (issue_rs1),
        .rd_addr2  (issue_rs2),
        .rd_data1  (rf_data1),
        .rd_data2  (rf_data2),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .dbg_req   (dbg_req),
        .dbg_write (dbg_write),
        .dbg_addr  (dbg_addr),
        .dbg_wdata (dbg_wdata),
        .dbg_rdata (dbg_rdata)
    );

    operand_forward u_forward
    (
        .issue_rs1     (issue_rs1),
        .issue_rs2     (issue_rs2),
        .rf_data1      (rf_data1),
        .rf_data2      (rf_data2),
        .ex_wr_en      (wr_en),
        .ex_wr_addr    (wr_addr),
        .ex_result     (wr_data),
        .issue_use_imm (issue_use_imm),
        .issue_imm     (issue_imm),
        .op_a          (op_a),
        .op_b          (op_b)
    );

    // --------------------
    // EX stage
    // --------------------
    ex_writeback u_ex_wb
    (
        .CLK        (CLK),
        .RES_CPU    (RES_CPU),
        .issue_fire (issue_fire),
        .issue_op   (issue_op),
        .issue_rd   (issue_rd),
        .op_a       (op_a),
        .op_b       (op_b),
        .alu_result (alu_result),
        .mul_result (mul_result),
        .div_done   (div_done),
        .div_result (div_result),
        .ex_op      (ex_op),
        .ex_a       (ex_a),
        .ex_b       (ex_b),
        .div_start  (div_start),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

    int_alu u_alu
    (
        .op     (ex_op),
        .op_a   (ex_a),
        .op_b   (ex_b),
        .result (alu_result)
    );

    int_multiplier u_mul
    (
        .op     (ex_op),
        .op_a   (ex_a),
        .op_b   (ex_b),
        .result (mul_result)
    );

    // Divider takes the ID operands at the issue edge
    int_divider u_div
    (
        .CLK      (CLK),
        .RES_CPU  (RES_CPU),
        .start    (div_start),
        .op       (issue_op),
        .dividend (op_a),
        .divisor  (op_b),
        .busy     (busy),
        .done     (div_done),
        .result   (div_result)
    );

endmodule

// File: bench/int_exec_unit_assert.sv
// Protocol assertions for the execute unit
// Bound into int_exec_unit

`timescale 1ns/1ps

module int_exec_unit_assert
(
    input logic             CLK,
    input logic             RES_CPU,
    input logic             issue_valid,
    input logic             busy,
    input logic             dbg_req,
    input logic             dbg_write,
    input exec_pkg::xdata_t dbg_rdata
);

    // Host holds off while the divider runs
    no_issue_when_busy: assert property (@(posedge CLK) disable iff (RES_CPU)
        !(issue_valid && busy))
        else $error("issue_valid high while busy");

    idle_after_reset: assert property (@(posedge CLK) $fell(RES_CPU) |-> !busy)
        else $error("busy high after reset release");

    // Read data only follows a debug read
    rdata_zero_when_idle: assert property (@(posedge CLK) disable iff (RES_CPU)
        !$past(dbg_req && !dbg_write) |-> (dbg_rdata == '0))
        else $error("dbg_rdata nonzero without a preceding debug read");

endmodule

bind int_exec_unit int_exec_unit_assert u_assert
(
    .CLK         (CLK),
    .RES_CPU     (RES_CPU),
    .issue_valid (issue_valid),
    .busy        (busy),
    .dbg_req     (dbg_req),
    .dbg_write   (dbg_write),
    .dbg_rdata   (dbg_rdata)
);

// File: bench/tb_int_exec_unit.sv
// Testbench for the integer execute unit
// Drives the issue and debug ports and compares register contents with a reference model

`timescale 1ns/1ps

module tb_int_exec_unit;
    import exec_pkg::*;

    localparam realtime HALF_PERIOD     = 2.0;
    localparam realtime DRIVE_DLY       = 0.5;        // After the rising edge
    localparam int      RESET_CYCLES    = 5;
    localparam int      IDLE_TIMEOUT    = 50;         // Longer than one division
    localparam int      DRAIN_TIMEOUT   = 10;
    localparam int      DIV_BUSY_CYCLES = 33;         // Issue edge to result write
    localparam int      SEED            = 32'h2679;

    logic        CLK;
    logic        RES_CPU;
    logic        issue_valid;
    exec_op_e    issue_op;
    reg_idx_t    issue_rs1;
    reg_idx_t    issue_rs2;
    reg_idx_t    issue_rd;
    logic        issue_use_imm;
    xdata_t      issue_imm;
    logic        busy;
    logic        dbg_req;
    logic        dbg_write;
    reg_idx_t    dbg_addr;
    xdata_t      dbg_wdata;
    xdata_t      dbg_rdata;

    xdata_t      model [REG_COUNT];                   // Expected register contents
    xdata_t      exp_q [$];
    reg_idx_t    idx_q [$];
    logic        read_seen;
    xdata_t      cmp_exp;
    reg_idx_t    cmp_idx;
    xdata_t      corners [6] = '{32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF,
                                 32'h8000_0000, 32'h7FFF_FFFF, 32'hFFFF_FFF9};

    int_exec_unit i_dut
    (
        .CLK           (CLK),
        .RES_CPU       (RES_CPU),
        .issue_valid   (issue_valid),
        .issue_op      (issue_op),
        .issue_rs1     (issue_rs1),
        .issue_rs2     (issue_rs2),
        .issue_rd      (issue_rd),
        .issue_use_imm (issue_use_imm),
        .issue_imm     (issue_imm),
        .busy          (busy),
        .dbg_req       (dbg_req),
        .dbg_write     (dbg_write),
        .dbg_addr      (dbg_addr),
        .dbg_wdata     (dbg_wdata),
        .dbg_rdata     (dbg_rdata)
    );

    always #(HALF_PERIOD) CLK = ~CLK;

    // --------------------
    // Reference model
    // --------------------
    function automatic xdata_t expected_result(exec_op_e op, xdata_t a, xdata_t b);
        int          sa;
        int          sb;
        logic [4:0]  sh;
        logic [63:0] wide;
        sa = a;
        sb = b;
        sh = b[4:0];
        case (op)
            OP_ADD    : return a + b;
            OP_SUB    : return a - b;
            OP_SLL    : return a << sh;
            OP_SRL    : return a >> sh;
            OP_SRA    : return xdata_t'(sa >>> sh);
            OP_SLT    : return (sa < sb) ? 32'd1 : 32'd0;
            OP_SLTU   : return (a < b) ? 32'd1 : 32'd0;
            OP_XOR    : return a ^ b;
            OP_OR     : return a | b;
            OP_AND    : return a & b;
            OP_MIN    : return (sa < sb) ? a : b;
            OP_MAX    : return (sa < sb) ? b : a;
            OP_MINU   : return (a < b) ? a : b;
            OP_MAXU   : return (a < b) ? b : a;
            OP_MUL    : return a * b;
            OP_MULH   :
            begin
                wide = {{32{a[31]}}, a} * {{32{b[31]}}, b};   // Low 64 bits are exact
                return wide[63:32];
            end
            OP_MULHU  :
            begin
                wide = {32'd0, a} * {32'd0, b};
                return wide[63:32];
            end
            OP_MULHSU :
            begin
                wide = {{32{a[31]}}, a} * {32'd0, b};
                return wide[63:32];
            end
            OP_DIV    :
            begin
                if (b == '0)
                    return '1;
                else if ((a == 32'h8000_0000) && (b == '1))
                    return 32'h8000_0000;
                return xdata_t'(sa / sb);                     // Truncates toward zero
            end
            OP_DIVU   : return (b == '0) ? '1 : a / b;
            OP_REM    :
            begin
                if (b == '0)
                    return a;
                else if ((a == 32'h8000_0000) && (b == '1))
                    return '0;
                return xdata_t'(sa % sb);                     // Sign of the dividend
            end
            OP_REMU   : return (b == '0) ? a : a % b;
            default   : return '0;
        endcase
    endfunction

    function automatic xdata_t pick_operand();
        case ($urandom_range(5, 0))
            0       : return 32'h8000_0000;
            1       : return 32'hFFFF_FFFF;
            2       : return xdata_t'($urandom_range(15, 0));
            default : return $urandom();
        endcase
    endfunction

    // --------------------
    // Stimulus tasks
    // --------------------
    task automatic next_cycle();
        @(posedge CLK);
        #(DRIVE_DLY);
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (busy && (waited < IDLE_TIMEOUT))
        begin
            next_cycle();
            waited++;
        end
        assert (!busy) else
        begin
            $display("Timeout: busy still high after %0d cycles", IDLE_TIMEOUT);
            $display("Checks failed");
            $fatal(1, "divider never finished");
        end
    endtask

    task automatic issue_instr(exec_op_e op, reg_idx_t rs1, reg_idx_t rs2, reg_idx_t rd,
                               logic use_imm, xdata_t imm);
        xdata_t a;
        xdata_t b;
        wait_idle();
        a             = model[rs1];
        b             = use_imm ? imm : model[rs2];
        issue_valid   = 1'b1;
        issue_op      = op;
        issue_rs1     = rs1;
        issue_rs2     = rs2;
        issue_rd      = rd;
        issue_use_imm = use_imm;
        issue_imm     = imm;
        next_cycle();
        issue_valid   = 1'b0;
        if (rd != '0)
            model[rd] = expected_result(op, a, b);
    endtask

    task automatic write_reg(reg_idx_t idx, xdata_t val);
        dbg_req   = 1'b1;
        dbg_write = 1'b1;
        dbg_addr  = idx;
        dbg_wdata = val;
        next_cycle();
        dbg_req   = 1'b0;
        dbg_write = 1'b0;
        model[idx] = (idx == '0) ? '0 : val;                 // x0 stays zero
    endtask

    task automatic read_reg(reg_idx_t idx);
        dbg_req   = 1'b1;
        dbg_write = 1'b0;
        dbg_addr  = idx;
        exp_q.push_back(model[idx]);
        idx_q.push_back(idx);
        next_cycle();
        dbg_req   = 1'b0;
    endtask

    task automatic read_all_regs();
        for (int r = 0; r < REG_COUNT; r++)
            read_reg(reg_idx_t'(r));
    endtask

    task automatic mul_case(xdata_t a, xdata_t b);
        write_reg(5'd1, a);
        write_reg(5'd2, b);
        issue_instr(OP_MUL,    5'd1, 5'd2, 5'd3, 1'b0, '0);
        issue_instr(OP_MULH,   5'd1, 5'd2, 5'd4, 1'b0, '0);
        issue_instr(OP_MULHU,  5'd1, 5'd2, 5'd5, 1'b0, '0);
        issue_instr(OP_MULHSU, 5'd1, 5'd2, 5'd6, 1'b0, '0);
        next_cycle();                                    // Last write lands
        for (int r = 3; r <= 6; r++)
            read_reg(reg_idx_t'(r));
    endtask

    task automatic div_run(exec_op_e op, reg_idx_t rd);
        int busy_cycles;
        issue_instr(op, 5'd1, 5'd2, rd, 1'b0, '0);
        busy_cycles = 0;
        while (busy && (busy_cycles < IDLE_TIMEOUT))
        begin
            next_cycle();
            busy_cycles++;
        end
        assert (busy_cycles == DIV_BUSY_CYCLES) else
        begin
            $display("FAILED at %0t: busy high for %0d cycles, expected %0d",
                     $time, busy_cycles, DIV_BUSY_CYCLES);
            $display("Checks failed");
            $fatal(1, "divider busy time mismatch");
        end
        read_reg(rd);
    endtask

    task automatic div_case(xdata_t a, xdata_t b);
        write_reg(5'd1, a);
        write_reg(5'd2, b);
        div_run(OP_DIV,  5'd7);
        div_run(OP_DIVU, 5'd8);
        div_run(OP_REM,  5'd9);
        div_run(OP_REMU, 5'd10);
    endtask

    // --------------------
    // Compare process
    // --------------------
    always @(posedge CLK or posedge RES_CPU)
    begin
        if (RES_CPU)
            read_seen <= 1'b0;
        else
            read_seen <= dbg_req && !dbg_write;          // Data valid after this edge
    end

    always @(negedge CLK)
    begin
        if (read_seen)
        begin
            cmp_exp = exp_q.pop_front();
            cmp_idx = idx_q.pop_front();
            assert (dbg_rdata == cmp_exp) else
            begin
                $display("FAILED at %0t: x%0d reads 0x%08h, expected 0x%08h",
                         $time, cmp_idx, dbg_rdata, cmp_exp);
                $display("Checks failed");
                $fatal(1, "register value mismatch");
            end
        end
    end

    initial
    begin : stimulus
        exec_op_e op;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        reg_idx_t prev_rd;
        logic     use_imm;
        int       waited;

        void'($urandom(SEED));
        CLK           = 1'b0;
        RES_CPU       = 1'b1;
        issue_valid   = 1'b0;
        issue_op      = OP_ADD;
        issue_rs1     = '0;
        issue_rs2     = '0;
        issue_rd      = '0;
        issue_use_imm = 1'b0;
        issue_imm     = '0;
        dbg_req       = 1'b0;
        dbg_write     = 1'b0;
        dbg_addr      = '0;
        dbg_wdata     = '0;
        for (int i = 0; i < REG_COUNT; i++)
            model[i] = '0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #(DRIVE_DLY);
        RES_CPU = 1'b0;

        // Reset state and x0
        read_all_regs();
        write_reg(5'd0, 32'hDEAD_BEEF);
        read_reg(5'd0);

        // Random ALU operations one at a time
        for (int r = 1; r < REG_COUNT; r++)
            write_reg(reg_idx_t'(r), pick_operand());
        for (int n = 0; n < 60; n++)
        begin
            op      = exec_op_e'(5'($urandom_range(13, 0)));
            rs1     = reg_idx_t'($urandom_range(31, 0));
            rs2     = reg_idx_t'($urandom_range(31, 0));
            rd      = reg_idx_t'($urandom_range(31, 0));
            use_imm = 1'($urandom_range(1, 0));
            issue_instr(op, rs1, rs2, rd, use_imm, pick_operand());
            next_cycle();
            read_reg(rd);
        end

        // Dependent chain where each op reads the previous destination
        prev_rd = 5'd1;
        for (int n = 0; n < 40; n++)
        begin
            op  = exec_op_e'(5'($urandom_range(17, 0)));
            rd  = reg_idx_t'($urandom_range(31, 1));
            rs2 = ((n % 3) == 0) ? prev_rd : reg_idx_t'($urandom_range(31, 0));
            issue_instr(op, prev_rd, rs2, rd, 1'b0, '0);
            prev_rd = rd;
        end
        next_cycle();
        read_all_regs();

        // Multiplier
        foreach (corners[i])
            foreach (corners[j])
                mul_case(corners[i], corners[j]);
        for (int n = 0; n < 12; n++)
            mul_case($urandom(), $urandom());

        // Divider with divide by zero and overflow
        foreach (corners[i])
            foreach (corners[j])
                div_case(corners[i], corners[j]);
        for (int n = 0; n < 12; n++)
            div_case($urandom(), ((n % 2) == 0) ? $urandom() : xdata_t'(-$urandom_range(9, 1)));

        waited = 0;
        while ((exp_q.size() != 0) && (waited < DRAIN_TIMEOUT))
        begin
            next_cycle();
            waited++;
        end
        if (exp_q.size() == 0)
        begin
            $display("All checks passed");
            $finish;
        end
        else
        begin
            $display("Timeout: %0d register reads never returned data", exp_q.size());
            $display("Checks failed");
            $fatal(1, "debug reads left pending");
        end
    end

endmodule

// File: int_exec_unit.f
src/exec_pkg.sv
src/int_regfile.sv
src/operand_forward.sv
src/int_alu.sv
src/int_multiplier.sv
src/int_divider.sv
src/ex_writeback.sv
src/int_exec_unit.sv
bench/int_exec_unit_assert.sv
bench/tb_int_exec_unit.sv

// File: Makefile
# Verilator build and run for the integer execute unit

VERILATOR ?= verilator
TOP       ?= tb_int_exec_unit
FLIST     ?= int_exec_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# Status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
